//--- hw/id_pkg.sv
// instruction decode definitions

package id_pkg;

    // ------------------------------------------------------------------------
    // widths
    // ------------------------------------------------------------------------
    typedef logic [31:0] word_t;      // insn, operand, immediate
    typedef logic [4:0]  reg_addr_t;  // gpr index
    typedef logic [6:0]  opcode_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [6:0]  funct7_t;

    // ------------------------------------------------------------------------
    // encodings
    // ------------------------------------------------------------------------
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_OP_IMM = 7'b0010011;
    localparam opcode_t OP_OP     = 7'b0110011;
    localparam opcode_t OP_STORE  = 7'b0100011;

    // loads
    localparam funct3_t F3_LB  = 3'b000;
    localparam funct3_t F3_LH  = 3'b001;
    localparam funct3_t F3_LW  = 3'b010;
    localparam funct3_t F3_LBU = 3'b100;
    localparam funct3_t F3_LHU = 3'b101;
    // stores
    localparam funct3_t F3_SB  = 3'b000;
    localparam funct3_t F3_SH  = 3'b001;
    localparam funct3_t F3_SW  = 3'b010;
    // alu group, shared by op and op-imm
    localparam funct3_t F3_ADD  = 3'b000;  // add, sub, addi
    localparam funct3_t F3_SLL  = 3'b001;
    localparam funct3_t F3_SLT  = 3'b010;
    localparam funct3_t F3_SLTU = 3'b011;
    localparam funct3_t F3_XOR  = 3'b100;
    localparam funct3_t F3_SR   = 3'b101;  // srl/sra by funct7
    localparam funct3_t F3_OR   = 3'b110;
    localparam funct3_t F3_AND  = 3'b111;

    localparam funct7_t F7_BASE = 7'b0000000;
    localparam funct7_t F7_ALT  = 7'b0100000;  // sub, sra

    typedef enum logic [3:0] {
        ALU_NOP, ALU_ADD, ALU_SUB, ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_XOR, ALU_OR, ALU_AND, ALU_SLT, ALU_SLTU
    } alu_op_e;

    typedef enum logic [3:0] {
        MEM_NOP, MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU,
        MEM_SB, MEM_SH, MEM_SW
    } mem_op_e;

    typedef enum logic {
        WB_ALU,  // alu result
        WB_CMP   // set-less-than result
    } wb_sel_e;

    // execute side buffering
    localparam int unsigned ID_EX_CREDITS = 2;
    localparam int unsigned CREDIT_W      = $clog2(ID_EX_CREDITS + 1);

endpackage

//--- hw/decode_if.sv
// decoded instruction bundle
`timescale 1ns/100ps

interface decode_if;

    id_pkg::alu_op_e   alu_op;        // alu operation
    id_pkg::word_t     alu_in_0;      // first alu operand
    id_pkg::word_t     alu_in_1;      // second alu operand
    id_pkg::mem_op_e   mem_op;        // load/store kind
    id_pkg::word_t     mem_wr_data;   // store data
    id_pkg::wb_sel_e   wb_sel;        // alu or cmp result
    logic              gpr_we;        // active high
    id_pkg::reg_addr_t dst_addr;      // rd
    logic [1:0]        src_reg_used;  // {rb, ra}
    logic              illegal;       // undefined encoding

    // decoder side
    modport src (
        output alu_op, alu_in_0, alu_in_1,
        output mem_op, mem_wr_data,
        output wb_sel, gpr_we, dst_addr,
        output src_reg_used, illegal
    );

    // pipeline register side
    modport dst (
        input alu_op, alu_in_0, alu_in_1,
        input mem_op, mem_wr_data,
        input wb_sel, gpr_we, dst_addr,
        input src_reg_used, illegal
    );

endinterface

//--- hw/insn_decoder.sv
// instruction decoder
`timescale 1ns/100ps

module insn_decoder (
    input  id_pkg::word_t     insn_i,     // from fetch
    input  id_pkg::word_t     ra_data_i,  // gpr read port 0
    input  id_pkg::word_t     rb_data_i,  // gpr read port 1
    output id_pkg::reg_addr_t ra_addr_o,
    output id_pkg::reg_addr_t rb_addr_o,
    decode_if.src             dec
);

    // ------------------------------------------------------------------------
    // field split
    // ------------------------------------------------------------------------
    id_pkg::opcode_t opcode;
    id_pkg::funct3_t funct3;
    id_pkg::funct7_t funct7;
    id_pkg::word_t   imm_i;
    id_pkg::word_t   imm_sh;
    id_pkg::word_t   imm_s;
    logic            f7_base;
    logic            f7_alt;
    logic            illegal;

    assign opcode = insn_i[6:0];
    assign funct3 = insn_i[14:12];
    assign funct7 = insn_i[31:25];

    assign ra_addr_o = insn_i[19:15];  // rs1
    assign rb_addr_o = insn_i[24:20];  // rs2

    assign imm_i  = {{20{insn_i[31]}}, insn_i[31:20]};
    assign imm_sh = {{27{insn_i[31]}}, insn_i[24:20]};  // shamt only
    assign imm_s  = {{20{insn_i[31]}}, insn_i[31:25], insn_i[11:7]};

    assign f7_base = (funct7 == id_pkg::F7_BASE);
    assign f7_alt  = (funct7 == id_pkg::F7_ALT);

    // fixed routing, independent of opcode
    assign dec.mem_wr_data = rb_data_i;     // stores write rb
    assign dec.dst_addr    = insn_i[11:7];  // rd
    assign dec.illegal     = illegal;

    // ------------------------------------------------------------------------
    // control decode
    // ------------------------------------------------------------------------
    always_comb begin
        dec.alu_op       = id_pkg::ALU_NOP;
        dec.alu_in_0     = ra_data_i;
        dec.alu_in_1     = rb_data_i;
        dec.mem_op       = id_pkg::MEM_NOP;
        dec.wb_sel       = id_pkg::WB_ALU;
        dec.gpr_we       = 1'b0;
        dec.src_reg_used = 2'b00;
        illegal          = 1'b0;

        case (opcode)
            id_pkg::OP_LOAD: begin
                case (funct3)
                    id_pkg::F3_LB:  dec.mem_op = id_pkg::MEM_LB;
                    id_pkg::F3_LH:  dec.mem_op = id_pkg::MEM_LH;
                    id_pkg::F3_LW:  dec.mem_op = id_pkg::MEM_LW;
                    id_pkg::F3_LBU: dec.mem_op = id_pkg::MEM_LBU;
                    id_pkg::F3_LHU: dec.mem_op = id_pkg::MEM_LHU;
                    default:        illegal    = 1'b1;
                endcase
                if (!illegal) begin
                    dec.alu_op       = id_pkg::ALU_ADD;  // address calc
                    dec.alu_in_1     = imm_i;
                    dec.gpr_we       = 1'b1;
                    dec.src_reg_used = 2'b01;            // ra only
                end
            end

            id_pkg::OP_OP_IMM: begin
                case (funct3)
                    id_pkg::F3_ADD:  dec.alu_op = id_pkg::ALU_ADD;
                    id_pkg::F3_SLL:  dec.alu_op = id_pkg::ALU_SLL;
                    id_pkg::F3_XOR:  dec.alu_op = id_pkg::ALU_XOR;
                    id_pkg::F3_OR:   dec.alu_op = id_pkg::ALU_OR;
                    id_pkg::F3_AND:  dec.alu_op = id_pkg::ALU_AND;
                    id_pkg::F3_SLT: begin
                        dec.alu_op = id_pkg::ALU_SLT;
                        dec.wb_sel = id_pkg::WB_CMP;
                    end
                    id_pkg::F3_SLTU: begin
                        dec.alu_op = id_pkg::ALU_SLTU;
                        dec.wb_sel = id_pkg::WB_CMP;
                    end
                    default: begin  // right shifts
                        if (f7_base)     dec.alu_op = id_pkg::ALU_SRL;
                        else if (f7_alt) dec.alu_op = id_pkg::ALU_SRA;
                        else             illegal    = 1'b1;
                    end
                endcase
                if (!illegal) begin
                    dec.alu_in_1     = (funct3 == id_pkg::F3_SR) ? imm_sh : imm_i;
                    dec.gpr_we       = 1'b1;
                    dec.src_reg_used = 2'b01;
                end
            end

            id_pkg::OP_OP: begin
                // alt funct7 only legal on add/sub and srl/sra
                if (!(f7_base || (f7_alt && (funct3 == id_pkg::F3_ADD ||
                                             funct3 == id_pkg::F3_SR)))) begin
                    illegal = 1'b1;
                end else begin
                    case (funct3)
                        id_pkg::F3_ADD: dec.alu_op = f7_alt ? id_pkg::ALU_SUB : id_pkg::ALU_ADD;
                        id_pkg::F3_SR:  dec.alu_op = f7_alt ? id_pkg::ALU_SRA : id_pkg::ALU_SRL;
                        id_pkg::F3_SLL: dec.alu_op = id_pkg::ALU_SLL;  // alu path, not cmp
                        id_pkg::F3_XOR: dec.alu_op = id_pkg::ALU_XOR;
                        id_pkg::F3_OR:  dec.alu_op = id_pkg::ALU_OR;
                        id_pkg::F3_AND: dec.alu_op = id_pkg::ALU_AND;
                        id_pkg::F3_SLT: begin
                            dec.alu_op = id_pkg::ALU_SLT;
                            dec.wb_sel = id_pkg::WB_CMP;
                        end
                        default: begin  // sltu
                            dec.alu_op = id_pkg::ALU_SLTU;
                            dec.wb_sel = id_pkg::WB_CMP;
                        end
                    endcase
                    dec.gpr_we       = 1'b1;
                    dec.src_reg_used = 2'b11;  // ra and rb
                end
            end

            id_pkg::OP_STORE: begin
                case (funct3)
                    id_pkg::F3_SB: dec.mem_op = id_pkg::MEM_SB;
                    id_pkg::F3_SH: dec.mem_op = id_pkg::MEM_SH;
                    id_pkg::F3_SW: dec.mem_op = id_pkg::MEM_SW;
                    default:       illegal    = 1'b1;
                endcase
                if (!illegal) begin
                    dec.alu_op       = id_pkg::ALU_ADD;
                    dec.alu_in_1     = imm_s;
                    dec.src_reg_used = 2'b11;  // base and data
                end
            end

            default: illegal = 1'b1;  // unknown opcode
        endcase
    end

endmodule

//--- hw/credit_counter.sv
// execute credit counter
`timescale 1ns/100ps

module credit_counter (
    input  logic clk,
    input  logic reset_i,
    input  logic issue_i,          // one item sent to execute
    input  logic credit_return_i,  // one slot freed in execute
    output logic has_credit_o
);

    // free slots on the execute side
    logic [id_pkg::CREDIT_W-1:0] credit_cnt;

    // ------------------------------------------------------------------------
    // count update
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset_i) begin
            credit_cnt <= id_pkg::ID_EX_CREDITS[id_pkg::CREDIT_W-1:0];  // all slots free
        end else begin
            case ({issue_i, credit_return_i})
                2'b10:   credit_cnt <= credit_cnt - 1'b1;  // consumed
                2'b01:   credit_cnt <= credit_cnt + 1'b1;  // returned
                default: credit_cnt <= credit_cnt;         // none or both
            endcase
        end
    end

    // issue allowed while any slot remains
    assign has_credit_o = (credit_cnt != '0);

endmodule

//--- hw/id_ex_reg.sv
// ID/EX pipeline register
`timescale 1ns/100ps

module id_ex_reg (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              if_valid_i,   // fetch offers an insn
    input  logic              has_credit_i, // execute can take one
    decode_if.dst             dec,
    output logic              issue_o,
    output logic              ex_valid_o,
    output id_pkg::alu_op_e   ex_alu_op_o,
    output id_pkg::word_t     ex_alu_in_0_o,
    output id_pkg::word_t     ex_alu_in_1_o,
    output id_pkg::mem_op_e   ex_mem_op_o,
    output id_pkg::word_t     ex_mem_wr_data_o,
    output id_pkg::wb_sel_e   ex_wb_sel_o,
    output logic              ex_gpr_we_o,
    output id_pkg::reg_addr_t ex_dst_addr_o,
    output logic [1:0]        ex_src_reg_used_o,
    output logic              ex_illegal_o
);

    // accept and issue are the same event
    assign issue_o = if_valid_i & has_credit_i;

    // ------------------------------------------------------------------------
    // valid bit
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset_i) begin
            ex_valid_o <= 1'b0;
        end else begin
            ex_valid_o <= issue_o;  // one cycle per issued item
        end
    end

    // ------------------------------------------------------------------------
    // payload, held between issues
    // ------------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (issue_o) begin
            ex_alu_op_o       <= dec.alu_op;
            ex_alu_in_0_o     <= dec.alu_in_0;
            ex_alu_in_1_o     <= dec.alu_in_1;
            ex_mem_op_o       <= dec.mem_op;
            ex_mem_wr_data_o  <= dec.mem_wr_data;
            ex_wb_sel_o       <= dec.wb_sel;
            ex_gpr_we_o       <= dec.gpr_we;
            ex_dst_addr_o     <= dec.dst_addr;
            ex_src_reg_used_o <= dec.src_reg_used;
            ex_illegal_o      <= dec.illegal;
        end
    end

endmodule

//--- hw/id_stage.sv
// instruction decode stage
`timescale 1ns/100ps

module id_stage (
    input  logic              clk,
    input  logic              reset_i,
    // fetch side, valid/ready
    input  logic              if_valid_i,
    input  id_pkg::word_t     if_insn_i,
    output logic              if_ready_o,
    // register file read ports
    output id_pkg::reg_addr_t gpr_rd_addr_0_o,
    output id_pkg::reg_addr_t gpr_rd_addr_1_o,
    input  id_pkg::word_t     gpr_rd_data_0_i,
    input  id_pkg::word_t     gpr_rd_data_1_i,
    // execute side, credit based
    input  logic              ex_credit_i,
    output logic              ex_valid_o,
    output id_pkg::alu_op_e   ex_alu_op_o,
    output id_pkg::word_t     ex_alu_in_0_o,
    output id_pkg::word_t     ex_alu_in_1_o,
    output id_pkg::mem_op_e   ex_mem_op_o,
    output id_pkg::word_t     ex_mem_wr_data_o,
    output id_pkg::wb_sel_e   ex_wb_sel_o,
    output logic              ex_gpr_we_o,
    output id_pkg::reg_addr_t ex_dst_addr_o,
    output logic [1:0]        ex_src_reg_used_o,
    output logic              ex_illegal_o
);

    logic issue;      // item leaves for execute
    decode_if dec_bus ();

    // ------------------------------------------------------------------------
    // decode, flow control, register
    // ------------------------------------------------------------------------
    insn_decoder u_decoder (
        .insn_i    (if_insn_i),
        .ra_data_i (gpr_rd_data_0_i),
        .rb_data_i (gpr_rd_data_1_i),
        .ra_addr_o (gpr_rd_addr_0_o),
        .rb_addr_o (gpr_rd_addr_1_o),
        .dec       (dec_bus)
    );

    // ready is simply credit available
    credit_counter u_credit (
        .clk             (clk),
        .reset_i         (reset_i),
        .issue_i         (issue),
        .credit_return_i (ex_credit_i),
        .has_credit_o    (if_ready_o)
    );

    id_ex_reg u_id_ex (
        .clk               (clk),
        .reset_i           (reset_i),
        .if_valid_i        (if_valid_i),
        .has_credit_i      (if_ready_o),
        .dec               (dec_bus),
        .issue_o           (issue),
        .ex_valid_o        (ex_valid_o),
        .ex_alu_op_o       (ex_alu_op_o),
        .ex_alu_in_0_o     (ex_alu_in_0_o),
        .ex_alu_in_1_o     (ex_alu_in_1_o),
        .ex_mem_op_o       (ex_mem_op_o),
        .ex_mem_wr_data_o  (ex_mem_wr_data_o),
        .ex_wb_sel_o       (ex_wb_sel_o),
        .ex_gpr_we_o       (ex_gpr_we_o),
        .ex_dst_addr_o     (ex_dst_addr_o),
        .ex_src_reg_used_o (ex_src_reg_used_o),
        .ex_illegal_o      (ex_illegal_o)
    );

endmodule

//--- verif/id_ref_model.svh
// decode reference model
`ifndef ID_REF_MODEL_SVH
`define ID_REF_MODEL_SVH

// expected ID/EX fields for one instruction
typedef struct packed {
    id_pkg::alu_op_e   alu_op;
    id_pkg::word_t     alu_in_0;
    id_pkg::word_t     alu_in_1;
    id_pkg::mem_op_e   mem_op;
    id_pkg::word_t     mem_wr_data;
    id_pkg::wb_sel_e   wb_sel;
    logic              gpr_we;
    id_pkg::reg_addr_t dst_addr;
    logic [1:0]        src_used;   // {rb, ra}
    logic              illegal;
} dec_expect_t;

// ---------------------------------------------------------------------------
// encoders
// ---------------------------------------------------------------------------
function automatic id_pkg::word_t enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3,
                                       input logic [4:0] rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
endfunction

function automatic id_pkg::word_t enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                       input logic [2:0] f3, input logic [4:0] rd,
                                       input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
endfunction

function automatic id_pkg::word_t enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                       input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], id_pkg::OP_STORE};  // imm split around rs
endfunction

// ---------------------------------------------------------------------------
// prediction
// ---------------------------------------------------------------------------
// alu operation by funct3, alt picks sub or sra
function automatic id_pkg::alu_op_e alu_of(input logic [2:0] f3, input logic alt);
    case (f3)
        3'd0:    return alt ? id_pkg::ALU_SUB : id_pkg::ALU_ADD;
        3'd1:    return id_pkg::ALU_SLL;
        3'd2:    return id_pkg::ALU_SLT;
        3'd3:    return id_pkg::ALU_SLTU;
        3'd4:    return id_pkg::ALU_XOR;
        3'd5:    return alt ? id_pkg::ALU_SRA : id_pkg::ALU_SRL;
        3'd6:    return id_pkg::ALU_OR;
        default: return id_pkg::ALU_AND;
    endcase
endfunction

function automatic dec_expect_t predict(input id_pkg::word_t insn, input id_pkg::word_t ra,
                                        input id_pkg::word_t rb);
    dec_expect_t   e;
    logic [6:0]    op;
    logic [2:0]    f3;
    logic [6:0]    f7;
    id_pkg::word_t imm_i;
    op    = insn[6:0];
    f3    = insn[14:12];
    f7    = insn[31:25];
    imm_i = {{20{insn[31]}}, insn[31:20]};
    // what an illegal encoding leaves behind
    e.alu_op      = id_pkg::ALU_NOP;
    e.alu_in_0    = ra;
    e.alu_in_1    = rb;
    e.mem_op      = id_pkg::MEM_NOP;
    e.mem_wr_data = rb;
    e.wb_sel      = id_pkg::WB_ALU;
    e.gpr_we      = 1'b0;
    e.dst_addr    = insn[11:7];
    e.src_used    = 2'b00;
    e.illegal     = 1'b1;
    if (op == id_pkg::OP_OP &&
        (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)))) begin
        e.alu_op   = alu_of(f3, f7[5]);
        e.gpr_we   = 1'b1;
        e.src_used = 2'b11;
        e.illegal  = 1'b0;
    end else if (op == id_pkg::OP_OP_IMM && (f3 != 3'd5 || f7 == 7'h00 || f7 == 7'h20)) begin
        e.alu_op   = alu_of(f3, f3 == 3'd5 && f7[5]);
        e.alu_in_1 = (f3 == 3'd5) ? {{27{insn[31]}}, insn[24:20]} : imm_i;  // shamt only
        e.gpr_we   = 1'b1;
        e.src_used = 2'b01;
        e.illegal  = 1'b0;
    end else if (op == id_pkg::OP_LOAD && f3 != 3'd3 && f3 < 3'd6) begin
        e.alu_op   = id_pkg::ALU_ADD;
        e.alu_in_1 = imm_i;
        e.mem_op   = (f3 == 3'd0) ? id_pkg::MEM_LB :
                     (f3 == 3'd1) ? id_pkg::MEM_LH :
                     (f3 == 3'd2) ? id_pkg::MEM_LW :
                     (f3 == 3'd4) ? id_pkg::MEM_LBU : id_pkg::MEM_LHU;
        e.gpr_we   = 1'b1;
        e.src_used = 2'b01;
        e.illegal  = 1'b0;
    end else if (op == id_pkg::OP_STORE && f3 < 3'd3) begin
        e.alu_op   = id_pkg::ALU_ADD;
        e.alu_in_1 = {{20{insn[31]}}, insn[31:25], insn[11:7]};
        e.mem_op   = (f3 == 3'd0) ? id_pkg::MEM_SB :
                     (f3 == 3'd1) ? id_pkg::MEM_SH : id_pkg::MEM_SW;
        e.src_used = 2'b11;
        e.illegal  = 1'b0;
    end
    if (e.alu_op == id_pkg::ALU_SLT || e.alu_op == id_pkg::ALU_SLTU) begin
        e.wb_sel = id_pkg::WB_CMP;  // set-less-than result
    end
    return e;
endfunction

`endif

//--- verif/tb_id_stage.sv
// decode stage testbench
`timescale 1ns/100ps

module tb_id_stage;

    localparam int TIMEOUT = 50;  // cycles per wait

    logic              clk;
    logic              reset_i;
    logic              if_valid_i;
    id_pkg::word_t     if_insn_i;
    logic              if_ready_o;
    id_pkg::reg_addr_t gpr_rd_addr_0_o;
    id_pkg::reg_addr_t gpr_rd_addr_1_o;
    id_pkg::word_t     gpr_rd_data_0_i;
    id_pkg::word_t     gpr_rd_data_1_i;
    logic              ex_credit_i;
    logic              ex_valid_o;
    id_pkg::alu_op_e   ex_alu_op_o;
    id_pkg::word_t     ex_alu_in_0_o;
    id_pkg::word_t     ex_alu_in_1_o;
    id_pkg::mem_op_e   ex_mem_op_o;
    id_pkg::word_t     ex_mem_wr_data_o;
    id_pkg::wb_sel_e   ex_wb_sel_o;
    logic              ex_gpr_we_o;
    id_pkg::reg_addr_t ex_dst_addr_o;
    logic [1:0]        ex_src_reg_used_o;
    logic              ex_illegal_o;

    id_pkg::word_t     regs [32];      // register file contents
    integer            seed = 32221;
    int                checks = 0;
    int                errors = 0;

    // register file, same-cycle read
    assign gpr_rd_data_0_i = regs[gpr_rd_addr_0_o];
    assign gpr_rd_data_1_i = regs[gpr_rd_addr_1_o];

    id_stage dut (.*);

    `include "id_ref_model.svh"

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;       // 100 ns period
    end

    // ------------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------------
    task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    function automatic dec_expect_t expect_for(input id_pkg::word_t insn);
        return predict(insn, regs[insn[19:15]], regs[insn[24:20]]);
    endfunction

    task automatic check_outputs(input dec_expect_t e);
        check(32'(ex_alu_op_o), 32'(e.alu_op), "alu_op");
        check(ex_alu_in_0_o, e.alu_in_0, "alu_in_0");
        check(ex_alu_in_1_o, e.alu_in_1, "alu_in_1");
        check(32'(ex_mem_op_o), 32'(e.mem_op), "mem_op");
        check(ex_mem_wr_data_o, e.mem_wr_data, "mem_wr_data");
        check(32'(ex_wb_sel_o), 32'(e.wb_sel), "wb_sel");
        check(32'(ex_gpr_we_o), 32'(e.gpr_we), "gpr_we");
        check(32'(ex_dst_addr_o), 32'(e.dst_addr), "dst_addr");
        check(32'(ex_src_reg_used_o), 32'(e.src_used), "src_reg_used");
        check(32'(ex_illegal_o), 32'(e.illegal), "illegal");
    endtask

    // called at a falling edge, returns with ready high or after the timeout
    task automatic wait_ready(input string what);
        int n;
        n = 0;
        while (!if_ready_o && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!if_ready_o) begin
            $display("timeout at %0t: if_ready_o never rose while %s", $time, what);
            errors++;
        end
    endtask

    // one instruction through, then execute hands its credit back
    task automatic send_one(input id_pkg::word_t insn);
        @(posedge clk);
        if_valid_i <= 1'b1;
        if_insn_i  <= insn;
        @(negedge clk);
        wait_ready("offering an instruction");
        // read ports follow rs1 and rs2
        check(32'(gpr_rd_addr_0_o), 32'(insn[19:15]), "gpr_rd_addr_0_o");
        check(32'(gpr_rd_addr_1_o), 32'(insn[24:20]), "gpr_rd_addr_1_o");
        @(posedge clk);                // accept edge
        if_valid_i <= 1'b0;
        @(negedge clk);
        check(32'(ex_valid_o), 32'd1, "ex_valid_o one cycle after accept");
        check_outputs(expect_for(insn));
        @(posedge clk);
        ex_credit_i <= 1'b1;
        @(posedge clk);
        ex_credit_i <= 1'b0;
    endtask

    task automatic report(input string name, input int e0);
        $display("%s: %0d errors", name, errors - e0);
    endtask

    // ------------------------------------------------------------------------
    // tests
    // ------------------------------------------------------------------------
    task automatic reset_state();
        int e0;
        e0 = errors;
        @(negedge clk);
        check(32'(ex_valid_o), 32'd0, "ex_valid_o after reset");
        check(32'(if_ready_o), 32'd1, "if_ready_o after reset");
        report("reset state", e0);
    endtask

    task automatic reg_reg_ops();
        logic [31:0] r;
        logic [2:0]  f3;
        logic [6:0]  f7;
        int          e0;
        e0 = errors;
        // all eight funct3 with base funct7, then sub and sra
        for (int k = 0; k < 10; k++) begin
            r  = $random(seed);
            f3 = (k < 8) ? k[2:0] : ((k == 8) ? id_pkg::F3_ADD : id_pkg::F3_SR);
            f7 = (k < 8) ? id_pkg::F7_BASE : id_pkg::F7_ALT;
            send_one(enc_r(f7, r[14:10], r[9:5], f3, r[4:0], id_pkg::OP_OP));
        end
        report("register-register", e0);
    endtask

    task automatic reg_imm_ops();
        logic [2:0]  f3s [9];
        logic [31:0] r;
        logic [11:0] imm;
        int          e0;
        // addi xori ori andi slli srli srai slti sltiu
        f3s = '{3'd0, 3'd4, 3'd6, 3'd7, 3'd1, 3'd5, 3'd5, 3'd2, 3'd3};
        e0  = errors;
        for (int k = 0; k < 9; k++) begin
            r   = $random(seed);
            imm = r[31:20];
            if (f3s[k] == 3'd1 || f3s[k] == 3'd5) begin
                imm = {(k == 6) ? id_pkg::F7_ALT : id_pkg::F7_BASE, r[24:20]};  // shamt form
            end
            send_one(enc_i(imm, r[9:5], f3s[k], r[4:0], id_pkg::OP_OP_IMM));
        end
        report("register-immediate", e0);
    endtask

    task automatic load_store_ops();
        logic [2:0]  ld_f3 [5];
        logic [31:0] r;
        int          e0;
        ld_f3 = '{3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
        e0    = errors;
        for (int k = 0; k < 5; k++) begin
            r = $random(seed);
            send_one(enc_i(r[31:20], r[9:5], ld_f3[k], r[4:0], id_pkg::OP_LOAD));
        end
        for (int k = 0; k < 3; k++) begin
            r = $random(seed);
            send_one(enc_s(r[31:20], r[14:10], r[9:5], k[2:0]));  // sb sh sw
        end
        report("loads and stores", e0);
    endtask

    task automatic illegal_encodings();
        id_pkg::word_t bad [5];
        logic [31:0]   r;
        int            e0;
        e0     = errors;
        r      = $random(seed);
        bad[0] = enc_i(r[31:20], r[9:5], 3'd0, r[4:0], 7'b1101111);       // jal opcode
        bad[1] = enc_i(r[31:20], r[9:5], 3'd3, r[4:0], id_pkg::OP_LOAD);  // no such load
        bad[2] = enc_r(7'h01, r[14:10], r[9:5], id_pkg::F3_SR, r[4:0], id_pkg::OP_OP_IMM);
        bad[3] = enc_r(id_pkg::F7_ALT, r[14:10], r[9:5], id_pkg::F3_SLL, r[4:0], id_pkg::OP_OP);
        bad[4] = enc_r(7'h01, r[14:10], r[9:5], id_pkg::F3_ADD, r[4:0], id_pkg::OP_OP);
        for (int k = 0; k < 5; k++) begin
            send_one(bad[k]);
            // legal insn on the bus with valid low, must not reach the register
            if_insn_i <= enc_r(id_pkg::F7_BASE, r[14:10], r[9:5], id_pkg::F3_ADD, r[4:0],
                               id_pkg::OP_OP);
            @(posedge clk);
            @(negedge clk);
            check(32'(ex_illegal_o), 32'd1, "illegal flag held after issue");
        end
        report("illegal encodings", e0);
    endtask

    task automatic credit_backpressure();
        id_pkg::word_t held;
        logic [31:0]   r;
        int            e0;
        e0   = errors;
        r    = $random(seed);
        held = enc_s(r[31:20], r[14:10], r[9:5], id_pkg::F3_SW);
        // fill every execute slot, no credits back
        @(posedge clk);
        if_valid_i <= 1'b1;
        for (int k = 0; k < id_pkg::ID_EX_CREDITS; k++) begin
            if_insn_i <= enc_r(id_pkg::F7_BASE, r[14:10], r[9:5], id_pkg::F3_ADD, r[4:0],
                               id_pkg::OP_OP);
            @(negedge clk);
            wait_ready("filling an execute slot");
            @(posedge clk);
        end
        if_insn_i <= held;             // fetch keeps offering this one
        @(negedge clk);
        check(32'(if_ready_o), 32'd0, "if_ready_o with no credits");
        repeat (4) begin
            @(negedge clk);
            check(32'(ex_valid_o), 32'd0, "no issue without a credit");
            check(32'(if_ready_o), 32'd0, "if_ready_o held low");
        end
        @(posedge clk);
        ex_credit_i <= 1'b1;
        @(posedge clk);
        ex_credit_i <= 1'b0;
        @(negedge clk);
        check(32'(if_ready_o), 32'd1, "if_ready_o one cycle after credit");
        @(posedge clk);                // held insn goes here
        if_valid_i <= 1'b0;
        @(negedge clk);
        check(32'(ex_valid_o), 32'd1, "held insn issues after credit");
        check_outputs(expect_for(held));
        // one credit back, then issue and return in the same cycle
        @(posedge clk);
        ex_credit_i <= 1'b1;
        @(posedge clk);
        if_valid_i <= 1'b1;
        if_insn_i  <= enc_i(r[31:20], r[9:5], id_pkg::F3_LW, r[4:0], id_pkg::OP_LOAD);
        @(negedge clk);
        check(32'(if_ready_o), 32'd1, "if_ready_o with one credit");
        @(posedge clk);                // issue and return together
        if_valid_i  <= 1'b0;
        ex_credit_i <= 1'b0;
        @(negedge clk);
        check(32'(ex_valid_o), 32'd1, "issue alongside a credit return");
        check(32'(if_ready_o), 32'd1, "if_ready_o after issue with return");
        report("credit back-pressure", e0);
    endtask

    // ------------------------------------------------------------------------
    // sequence
    // ------------------------------------------------------------------------
    initial begin
        regs[0] = '0;                  // x0 reads zero
        for (int i = 1; i < 32; i++) begin
            regs[i] = $random(seed);
        end
        reset_i     <= 1'b1;
        if_valid_i  <= 1'b0;
        if_insn_i   <= '0;
        ex_credit_i <= 1'b0;
        repeat (16) @(posedge clk);
        reset_i <= 1'b0;
        reset_state();
        reg_reg_ops();
        reg_imm_ops();
        load_store_ops();
        illegal_encodings();
        credit_backpressure();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

//--- tb.f
+incdir+verif
hw/id_pkg.sv
hw/decode_if.sv
hw/insn_decoder.sv
hw/credit_counter.sv
hw/id_ex_reg.sv
hw/id_stage.sv
verif/tb_id_stage.sv

//--- Makefile
VERILATOR  := verilator
TOP        := tb_id_stage
RTL_TOP    := id_stage
FILELIST   := tb.f
FLAGS      := --binary --timing -j 0
LINT_FLAGS := --lint-only -Wall
OBJ_DIR    := obj_dir
LOG        := sim.log
RTL_SRCS   := hw/id_pkg.sv hw/decode_if.sv hw/insn_decoder.sv hw/credit_counter.sv \
              hw/id_ex_reg.sv hw/id_stage.sv

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "ALL CHECKS PASSED" $(LOG) || { echo "simulation failed"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
